//--- hdl/dodge_pkg.sv
// Dodge game core shared types
// Field geometry, player and button records, game states
`default_nettype none

package dodge_pkg;

	// ==================================================
	// Field geometry
	// ==================================================
	localparam int FIELD_W = 8;
	localparam int FIELD_H = 8;
	localparam int SCORE_W = 8;

	// One bit per column with the MSB as the leftmost column
	typedef logic [FIELD_W-1:0] row_t;

	// Row 0 is the bottom row where the players sit
	typedef struct packed {
		row_t [FIELD_H-1:0] rows;
	} field_t;

	// Button levels of one player
	typedef struct packed {
		logic left;
		logic right;
	} btn_t;

	// Alive flag and one-hot column
	typedef struct packed {
		logic alive;
		row_t pos;
	} player_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_over = 2'd2
	} game_state_t;

endpackage

`default_nettype wire

//--- hdl/player_ctrl.sv
// Dodge player control
// One-hot position with button edge detection, edge clamping and alive flag
`timescale 1ns/1ps
`default_nettype none

module player_ctrl #(
	parameter dodge_pkg::row_t INIT_POS = dodge_pkg::row_t'(1)
) (
	input  wire logic               clk_50,
	input  wire logic               rst_n,
	input  wire dodge_pkg::btn_t    btn,
	input  wire logic               running,
	input  wire logic               game_clear,
	input  wire logic               hit,
	output dodge_pkg::player_t      player
);

	// ==================================================
	// Button edge detection
	// ==================================================
	dodge_pkg::btn_t btn_q;
	dodge_pkg::btn_t rise;
	logic move_left;
	logic move_right;

	assign rise = btn & ~btn_q;

	// Both buttons together cancel out
	assign move_left  = rise.left && !btn.right && !player.pos[dodge_pkg::FIELD_W-1];
	assign move_right = rise.right && !btn.left && !player.pos[0];

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			btn_q <= '0;
		end else begin
			btn_q <= btn;
		end
	end

	// ==================================================
	// Position and alive flag
	// ==================================================
	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			player.alive <= 1'b1;
			player.pos   <= INIT_POS;
		end else if (game_clear) begin
			player.alive <= 1'b1;
			player.pos   <= INIT_POS;
		end else if (running && player.alive) begin
			// Obstacle in our column kills the player
			if (hit) begin
				player.alive <= 1'b0;
			end

			// Left goes toward the MSB
			if (move_left) begin
				player.pos <= {player.pos[dodge_pkg::FIELD_W-2:0], 1'b0};
			end else if (move_right) begin
				player.pos <= {1'b0, player.pos[dodge_pkg::FIELD_W-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tick_timer.sv
// Game tick timer
// One-cycle tick every TICK_CYCLES clocks while the game runs
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
	parameter int TICK_CYCLES = 2_000_000
) (
	input  wire logic clk_50,
	input  wire logic rst_n,
	input  wire logic running,
	input  wire logic game_clear,
	output logic      tick
);

	localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_CYCLES - 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	assign wrap = (cnt == CNT_LAST);

	// Stale count must not fire during the clear cycle
	assign tick = running && !game_clear && wrap;

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (game_clear) begin
			cnt <= '0;
		end else if (running) begin
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/field_scroller.sv
// Dodge field scroller
// Eight row registers shifting down per tick, new top rows from an LFSR
`timescale 1ns/1ps
`default_nettype none

module field_scroller (
	input  wire logic         clk_50,
	input  wire logic         rst_n,
	input  wire logic         game_clear,
	input  wire logic         tick,
	output dodge_pkg::field_t field
);

	// ==================================================
	// Random row source
	// ==================================================
	// Maximal length polynomial x^8 + x^6 + x^5 + x^4 + 1
	localparam logic [7:0] LFSR_SEED = 8'hb5;

	logic [7:0] lfsr;
	logic       lfsr_fb;

	assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

	// Free running so each game sees a different sequence
	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[6:0], lfsr_fb};
		end
	end

	// ==================================================
	// Row registers
	// ==================================================
	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			field <= '0;
		end else if (game_clear) begin
			field <= '0;
		end else if (tick) begin
			// Row k takes row k+1, top row takes the LFSR
			field.rows <= {dodge_pkg::row_t'(lfsr), field.rows[dodge_pkg::FIELD_H-1:1]};
		end
	end

endmodule

`default_nettype wire

//--- hdl/game_ctrl.sv
// Dodge game control
// Idle/run/over FSM, hit detection, score counter and clear strobe
`timescale 1ns/1ps
`default_nettype none

module game_ctrl (
	input  wire logic                       clk_50,
	input  wire logic                       rst_n,
	input  wire logic                       start,
	input  wire logic                       tick,
	input  wire dodge_pkg::row_t            bottom_row,
	input  wire dodge_pkg::player_t         p1,
	input  wire dodge_pkg::player_t         p2,
	output logic                            running,
	output logic                            game_over,
	output logic                            game_clear,
	output logic                            hit1,
	output logic                            hit2,
	output logic [dodge_pkg::SCORE_W-1:0]   score
);

	dodge_pkg::game_state_t state;
	dodge_pkg::game_state_t state_nxt;
	logic start_ok;
	logic all_dead;
	logic any_alive;

	assign running   = (state == dodge_pkg::st_run);
	assign game_over = (state == dodge_pkg::st_over);

	assign start_ok  = start && (state != dodge_pkg::st_run);
	assign all_dead  = !p1.alive && !p2.alive;
	assign any_alive = p1.alive || p2.alive;

	// Overlap of the bottom row with a living player
	assign hit1 = running && p1.alive && (|(bottom_row & p1.pos));
	assign hit2 = running && p2.alive && (|(bottom_row & p2.pos));

	// ==================================================
	// State machine
	// ==================================================
	always_comb begin
		state_nxt = state;
		case (state)
			dodge_pkg::st_idle, dodge_pkg::st_over: begin
				if (start) begin
					state_nxt = dodge_pkg::st_run;
				end
			end
			dodge_pkg::st_run: begin
				// Players still show the old game during the clear cycle
				if (all_dead && !game_clear) begin
					state_nxt = dodge_pkg::st_over;
				end
			end
			default: begin
				state_nxt = dodge_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			state      <= dodge_pkg::st_idle;
			game_clear <= 1'b0;
		end else begin
			state      <= state_nxt;
			game_clear <= start_ok;
		end
	end

	// ==================================================
	// Score
	// ==================================================
	always_ff @(posedge clk_50 or negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
		end else if (game_clear) begin
			score <= '0;
		end else if (tick && any_alive) begin
			score <= score + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dodge_top.sv
// Dodge game core top level
// Two players, scrolling obstacle field, tick timer and game control
`timescale 1ns/1ps
`default_nettype none

module dodge_top #(
	parameter int TICK_CYCLES = 2_000_000
) (
	input  wire logic                      clk_50,
	input  wire logic                      rst_n,
	input  wire logic                      start,
	input  wire dodge_pkg::btn_t           p1_btn,
	input  wire dodge_pkg::btn_t           p2_btn,
	output dodge_pkg::field_t              field,
	output dodge_pkg::player_t             p1,
	output dodge_pkg::player_t             p2,
	output logic [dodge_pkg::SCORE_W-1:0]  score,
	output logic                           running,
	output logic                           game_over
);

	logic game_clear;
	logic tick;
	logic hit1;
	logic hit2;

	// ==================================================
	// Players
	// ==================================================
	player_ctrl #(
		.INIT_POS(8'b0100_0000)
	) u_player1 (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.btn        (p1_btn),
		.running    (running),
		.game_clear (game_clear),
		.hit        (hit1),
		.player     (p1)
	);

	player_ctrl #(
		.INIT_POS(8'b0000_0100)
	) u_player2 (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.btn        (p2_btn),
		.running    (running),
		.game_clear (game_clear),
		.hit        (hit2),
		.player     (p2)
	);

	// ==================================================
	// Field and timing
	// ==================================================
	tick_timer #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_tick_timer (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.running    (running),
		.game_clear (game_clear),
		.tick       (tick)
	);

	field_scroller u_field_scroller (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.game_clear (game_clear),
		.tick       (tick),
		.field      (field)
	);

	// Hits are judged on the bottom row only
	game_ctrl u_game_ctrl (
		.clk_50     (clk_50),
		.rst_n      (rst_n),
		.start      (start),
		.tick       (tick),
		.bottom_row (field.rows[0]),
		.p1         (p1),
		.p2         (p2),
		.running    (running),
		.game_over  (game_over),
		.game_clear (game_clear),
		.hit1       (hit1),
		.hit2       (hit2),
		.score      (score)
	);

endmodule

`default_nettype wire

//--- tb/tb_dodge.sv
// Dodge game core testbench
// Button cases from a data file plus scroll, score, hit and game over monitoring
`timescale 1ns/1ps
`default_nettype none

module tb_dodge;

	localparam int TICK_CYCLES = 20;
	localparam int CLK_HALF = 20;
	localparam int START_LIMIT = 10;
	localparam int OVER_LIMIT = 20000;
	localparam logic [31:0] SEED = 32'hb3ac0ceb;
	localparam dodge_pkg::row_t P1_INIT = 8'b0100_0000;
	localparam dodge_pkg::row_t P2_INIT = 8'b0000_0100;

	logic clk_50;
	logic rst_n;
	logic start;
	dodge_pkg::btn_t p1_btn;
	dodge_pkg::btn_t p2_btn;
	dodge_pkg::field_t field;
	dodge_pkg::player_t p1;
	dodge_pkg::player_t p2;
	logic [dodge_pkg::SCORE_W-1:0] score;
	logic running;
	logic game_over;

	int checks;
	int errors;
	logic check_en;

	// Last sample seen by the monitor
	dodge_pkg::field_t prev_field;
	dodge_pkg::player_t prev_p1;
	dodge_pkg::player_t prev_p2;
	logic [dodge_pkg::SCORE_W-1:0] prev_score;
	logic prev_running;

	dodge_top #(
		.TICK_CYCLES(TICK_CYCLES)
	) uut (
		.clk_50    (clk_50),
		.rst_n     (rst_n),
		.start     (start),
		.p1_btn    (p1_btn),
		.p2_btn    (p2_btn),
		.field     (field),
		.p1        (p1),
		.p2        (p2),
		.score     (score),
		.running   (running),
		.game_over (game_over)
	);

	initial begin
		clk_50 = 1'b0;
		forever #CLK_HALF clk_50 = ~clk_50;
	end

	// ==================================================
	// Checking and run control
	// ==================================================
	task automatic check_eq(input logic [8*24-1:0] name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERR %0s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic abort_run(input logic [8*48-1:0] msg);
		errors++;
		$display("%0s", msg);
		finish_run();
	endtask

	task automatic apply_reset();
		@(posedge clk_50);
		check_en = 1'b0;
		rst_n <= 1'b0;
		start <= 1'b0;
		p1_btn <= '0;
		p2_btn <= '0;
		repeat (5) @(posedge clk_50);
		rst_n <= 1'b1;
	endtask

	// Start press, then the cleared game is checked
	task automatic start_game(input logic [8*24-1:0] name);
		int n;
		@(posedge clk_50);
		check_en = 1'b0;
		start <= 1'b1;
		n = 0;
		@(negedge clk_50);
		while (!running && n < START_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		if (!running) begin
			abort_run("Timeout: running did not rise after start");
		end else begin
			@(posedge clk_50);
			start <= 1'b0;
			@(negedge clk_50);
			check_eq(name, '0, field);
			check_eq(name, '0, score);
			check_eq(name, {1'b1, P1_INIT}, p1);
			check_eq(name, {1'b1, P2_INIT}, p2);
			check_eq(name, 1, running);
			check_eq(name, 0, game_over);
			@(posedge clk_50);
			check_en = 1'b1;
		end
	endtask

	// One press is one cycle high and one cycle low after a random gap
	task automatic press_button(input int player, input dodge_pkg::btn_t level,
			input int count);
		int gap;
		for (int i = 0; i < count; i++) begin
			gap = $urandom % 4;
			repeat (gap) @(posedge clk_50);
			@(posedge clk_50);
			if (player == 1) begin
				p1_btn <= level;
			end else begin
				p2_btn <= level;
			end
			@(posedge clk_50);
			p1_btn <= '0;
			p2_btn <= '0;
		end
	endtask

	task automatic exercise_case(input logic [8*24-1:0] name, input logic in_run,
			input int player, input dodge_pkg::btn_t level, input int presses,
			input dodge_pkg::row_t exp_pos);
		apply_reset();
		if (in_run) begin
			start_game(name);
		end
		press_button(player, level, presses);
		repeat (2) @(posedge clk_50);
		@(negedge clk_50);
		if (player == 1) begin
			check_eq(name, exp_pos, p1.pos);
			check_eq(name, P2_INIT, p2.pos);
		end else begin
			check_eq(name, P1_INIT, p1.pos);
			check_eq(name, exp_pos, p2.pos);
		end
	endtask

	task automatic read_cases();
		int fd;
		int code;
		int player;
		int presses;
		logic bad_line;
		logic [8*24-1:0] name;
		logic [8*8-1:0] mode;
		logic [8*4-1:0] btn_code;
		logic [8*128-1:0] line;
		dodge_pkg::btn_t level;
		dodge_pkg::row_t exp_pos;
		fd = $fopen("tb/dodge_cases.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open tb/dodge_cases.txt");
		end else begin
			bad_line = 1'b0;
			while (!bad_line && !$feof(fd)) begin
				code = $fscanf(fd, "%s", name);
				if (code != 1) begin
					break;
				end
				if (name == "#") begin
					code = $fgets(line, fd);
				end else begin
					code = $fscanf(fd, "%s %d %s %d %b", mode, player, btn_code,
							presses, exp_pos);
					level = '0;
					if (btn_code == "L") begin
						level.left = 1'b1;
					end else if (btn_code == "R") begin
						level.right = 1'b1;
					end else if (btn_code == "B") begin
						level = 2'b11;
					end else begin
						bad_line = 1'b1;
					end
					if (code != 5 || (mode != "run" && mode != "idle")) begin
						bad_line = 1'b1;
					end
					if (!bad_line) begin
						exercise_case(name, mode == "run", player, level, presses, exp_pos);
					end
				end
			end
			$fclose(fd);
			if (bad_line) begin
				abort_run("Malformed line in the cases file");
			end
		end
	endtask

	// Let obstacles kill both players, then check the frozen game
	task automatic play_until_over();
		int n;
		dodge_pkg::field_t frozen_field;
		logic [dodge_pkg::SCORE_W-1:0] frozen_score;
		n = 0;
		@(negedge clk_50);
		while (!game_over && n < OVER_LIMIT) begin
			@(negedge clk_50);
			n++;
		end
		if (!game_over) begin
			abort_run("Timeout: game over never came");
		end else begin
			check_eq("over running", 0, running);
			check_eq("over p1 alive", 0, p1.alive);
			check_eq("over p2 alive", 0, p2.alive);
			frozen_field = field;
			frozen_score = score;
			repeat (3 * TICK_CYCLES) @(negedge clk_50);
			check_eq("frozen field", frozen_field, field);
			check_eq("frozen score", frozen_score, score);
			check_eq("frozen game over", 1, game_over);
		end
	endtask

	// ==================================================
	// Monitor for scroll, score, hits and game end
	// ==================================================
	always @(negedge clk_50) begin
		logic [dodge_pkg::SCORE_W-1:0] exp_score;
		logic exp_alive;
		logic any_alive;
		if (check_en && prev_running) begin
			any_alive = prev_p1.alive || prev_p2.alive;
			exp_score = prev_score;
			if (field != prev_field) begin
				check_eq("scroll", 64'(prev_field.rows[7:1]), 64'(field.rows[6:0]));
				check_eq("new top row", 1, |field.rows[7]);
				if (any_alive) begin
					exp_score = prev_score + 1'b1;
				end
			end
			check_eq("score step", exp_score, score);
			exp_alive = prev_p1.alive && !(|(prev_field.rows[0] & prev_p1.pos));
			check_eq("p1 alive", exp_alive, p1.alive);
			exp_alive = prev_p2.alive && !(|(prev_field.rows[0] & prev_p2.pos));
			check_eq("p2 alive", exp_alive, p2.alive);
			check_eq("running", any_alive, running);
			check_eq("game over", !any_alive, game_over);
		end
		prev_field = field;
		prev_p1 = p1;
		prev_p2 = p2;
		prev_score = score;
		prev_running = running;
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		start = 1'b0;
		p1_btn = '0;
		p2_btn = '0;
		checks = 0;
		errors = 0;
		check_en = 1'b0;

		apply_reset();
		@(negedge clk_50);
		check_eq("reset field", '0, field);
		check_eq("reset score", '0, score);
		check_eq("reset running", 0, running);
		check_eq("reset game over", 0, game_over);
		check_eq("reset p1", {1'b1, P1_INIT}, p1);
		check_eq("reset p2", {1'b1, P2_INIT}, p2);

		read_cases();

		apply_reset();
		start_game("full game start");
		play_until_over();
		start_game("restart");
		repeat (2 * TICK_CYCLES) @(posedge clk_50);
		finish_run();
	end

endmodule

`default_nettype wire

//--- tb/dodge_cases.txt
# name mode(run/idle) player button(L/R/B) presses expected_pos(binary, MSB is leftmost)
# player 1 starts at 01000000, player 2 at 00000100
p1_left_1 run 1 L 1 10000000
p1_left_clamp run 1 L 4 10000000
p1_right_1 run 1 R 1 00100000
p1_right_3 run 1 R 3 00001000
p1_right_6 run 1 R 6 00000001
p1_right_clamp run 1 R 9 00000001
p1_both run 1 B 3 01000000
p1_zero_presses run 1 L 0 01000000
# player 2
p2_right_1 run 2 R 1 00000010
p2_right_clamp run 2 R 5 00000001
p2_left_1 run 2 L 1 00001000
p2_left_2 run 2 L 2 00010000
p2_left_5 run 2 L 5 10000000
p2_left_clamp run 2 L 8 10000000
p2_both run 2 B 2 00000100
# presses before any start must not move
p1_idle_left idle 1 L 2 01000000
p1_idle_right idle 1 R 3 01000000
p1_idle_both idle 1 B 1 01000000
p2_idle_left idle 2 L 1 00000100
p2_idle_right idle 2 R 2 00000100

//--- flist.f
hdl/dodge_pkg.sv
hdl/player_ctrl.sv
hdl/tick_timer.sv
hdl/field_scroller.sv
hdl/game_ctrl.sv
hdl/dodge_top.sv
tb/tb_dodge.sv

//--- Bender.yml
package:
  name: dodge_game

sources:
  # Game core RTL, package first
  - files:
      - hdl/dodge_pkg.sv
      - hdl/player_ctrl.sv
      - hdl/tick_timer.sv
      - hdl/field_scroller.sv
      - hdl/game_ctrl.sv
      - hdl/dodge_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_dodge.sv
